// File: files.f
verilog/execPkg.sv
verilog/opQueue.sv
verilog/aluCore.sv
verilog/shiftCore.sv
verilog/resultMerge.sv
verilog/execStage.sv
testbench/execStageTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert \
        --top-module execStageTb \
        -f files.f \
        -o execSim; then
    echo "Verilator build failed"
    exit 1
fi

simOutput="$(./obj_dir/execSim)"
simStatus=$?
echo "$simOutput"

if [ "$simStatus" -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

# The run passes only if the testbench printed its pass line
if grep -qx "=== PASS ===" <<< "$simOutput"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1

// File: testbench/execStageTb.sv
// Execute stage testbench
`default_nettype none

module execStageTb;
    import execPkg::*;

    localparam int QUEUE_DEPTH = 4;
    localparam int RES_CREDITS = 2;

    // Instruction opcodes
    localparam opcodeT opcAddi     = 5'b01000;
    localparam opcodeT opcSubi     = 5'b01001;
    localparam opcodeT opcXori     = 5'b01010;
    localparam opcodeT opcAndni    = 5'b01011;
    localparam opcodeT opcRoli     = 5'b10100;
    localparam opcodeT opcSlli     = 5'b10101;
    localparam opcodeT opcRori     = 5'b10110;
    localparam opcodeT opcSrli     = 5'b10111;
    localparam opcodeT opcSlbi     = 5'b10010;
    localparam opcodeT opcLbi      = 5'b11000;
    localparam opcodeT opcBtr      = 5'b11001;
    localparam opcodeT opcRegShift = 5'b11010;  // Kind in funct
    localparam opcodeT opcRegAlu   = 5'b11011;  // Add, sub, xor, andn in funct
    localparam opcodeT opcSeq      = 5'b11100;
    localparam opcodeT opcSlt      = 5'b11101;
    localparam opcodeT opcSle      = 5'b11110;
    localparam opcodeT opcSco      = 5'b11111;

    // NOP, halt, jumps, branches and memory ops
    localparam opcodeT unsupportedOps [14] = '{
        5'b00000, 5'b00001, 5'b00010, 5'b00100, 5'b00101, 5'b00110, 5'b00111,
        5'b01100, 5'b01101, 5'b01110, 5'b01111, 5'b10000, 5'b10001, 5'b10011
    };

    logic   clk = 1'b0;
    logic   rstN;
    logic   opValid;
    opcodeT opcode;
    functT  funct;
    wordT   aIn;
    wordT   bIn;
    logic   resCredit = 1'b0;
    logic   opCredit;
    logic   resValid;
    wordT   result;
    logic   ovf;

    wordT        expRes[$];
    logic        expOvf[$];
    int          expCycle[$];  // Cycle count at acceptance
    int          dueQ[$];      // Cycle at which each downstream slot frees
    int          cycleCount = 0;
    int          sentOps = 0;
    int          resultsSeen = 0;
    int          spentCredits = 0;
    int          returnedCredits = 0;
    int          timedOp = -1;  // Op whose latency is checked
    int          creditDelay;
    logic        holdCredits;
    logic [31:0] rngState = 32'd8;

    execStage #(
        .QUEUE_DEPTH(QUEUE_DEPTH),
        .RES_CREDITS(RES_CREDITS)
    ) uut (
        .clk      (clk),
        .rstN     (rstN),
        .opValid  (opValid),
        .opcode   (opcode),
        .funct    (funct),
        .aIn      (aIn),
        .bIn      (bIn),
        .resCredit(resCredit),
        .opCredit (opCredit),
        .resValid (resValid),
        .result   (result),
        .ovf      (ovf)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic wordT nextWord();
        rngState = xorshift(rngState);
        return rngState[15:0];
    endfunction

    function automatic int senderCredits();
        return QUEUE_DEPTH - spentCredits + returnedCredits;
    endfunction

    // Kind codes as in the register form: sll, srl, rol, ror
    function automatic wordT shiftModel(logic [1:0] kind, wordT a, shamtT n);
        logic [31:0] doubled;
        doubled = {a, a};
        case (kind)
            2'd0: return a << n;
            2'd1: return a >> n;
            2'd2: begin
                doubled = doubled << n;
                return doubled[31:16];  // Wrapped bits land in the low end
            end
            default: begin
                doubled = doubled >> n;
                return doubled[15:0];
            end
        endcase
    endfunction

    // Reference result, overflow in bit 16
    function automatic logic [16:0] expectedOf(opcodeT opc, functT fn, wordT a, wordT b);
        int         sum;
        int         dif;
        logic [1:0] sel;
        wordT       r;
        wordT       rev;
        logic       v;
        sum = int'($signed(a)) + int'($signed(b));
        dif = int'($signed(b)) - int'($signed(a));
        r = '0;
        v = 1'b0;
        rev = {<<{a}};
        case (opc)
            opcAddi, opcSubi, opcXori, opcAndni, opcRegAlu: begin
                sel = (opc == opcRegAlu) ? fn : opc[1:0];
                case (sel)
                    2'b00: begin
                        r = a + b;
                        v = (sum > 32767) || (sum < -32768);
                    end
                    2'b01: begin
                        r = b - a;  // B minus A
                        v = (dif > 32767) || (dif < -32768);
                    end
                    2'b10: r = a ^ b;
                    default: r = a & ~b;
                endcase
            end
            opcRoli:     r = shiftModel(2'd2, a, b[3:0]);
            opcSlli:     r = shiftModel(2'd0, a, b[3:0]);
            opcRori:     r = shiftModel(2'd3, a, b[3:0]);
            opcSrli:     r = shiftModel(2'd1, a, b[3:0]);
            opcRegShift: r = shiftModel(fn, a, b[3:0]);
            opcSeq:      r = {15'b0, a == b};
            opcSlt:      r = {15'b0, $signed(a) < $signed(b)};
            opcSle:      r = {15'b0, $signed(a) <= $signed(b)};
            opcSco:      r = {15'b0, (int'(a) + int'(b)) > 65535};
            opcLbi:      r = b;
            opcSlbi:     r = {a[7:0], 8'h00} | b;
            opcBtr:      r = rev;
            default:     r = '0;  // Left to other stages
        endcase
        return {v, r};
    endfunction

    task automatic stopWithFailure();
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    task automatic reportError(string msg);
        $display("ERROR at time %0t: %s", $time, msg);
        stopWithFailure();
    endtask

    task automatic checkWord(string what, wordT expected, wordT actual);
        if (actual !== expected) begin
            $display("MISMATCH at time %0t: %s expected %h, got %h", $time, what, expected,
                     actual);
            stopWithFailure();
        end
    endtask

    task automatic checkOvf(string what, logic expected, logic actual);
        if (actual !== expected) begin
            $display("MISMATCH at time %0t: %s expected %b, got %b", $time, what, expected,
                     actual);
            stopWithFailure();
        end
    endtask

    task automatic checkCycles(string what, int expected, int actual);
        if (actual != expected) begin
            $display("MISMATCH at time %0t: %s expected %0d cycles, got %0d", $time, what,
                     expected, actual);
            stopWithFailure();
        end
    endtask

    // Called just after a rising edge, returns after the accepting edge
    task automatic sendOp(opcodeT opc, functT fn, wordT a, wordT b);
        logic [16:0] expected;
        while (senderCredits() == 0) begin
            opValid <= 1'b0;  // Wait for a credit
            @(posedge clk);
        end
        expected = expectedOf(opc, fn, a, b);
        expRes.push_back(expected[15:0]);
        expOvf.push_back(expected[16]);
        expCycle.push_back(cycleCount + 1);
        spentCredits++;
        sentOps++;
        opValid <= 1'b1;
        opcode  <= opc;
        funct   <= fn;
        aIn     <= a;
        bIn     <= b;
        @(posedge clk);
    endtask

    task automatic finishTest();
        opValid <= 1'b0;
        while (expRes.size() != 0) @(posedge clk);
        while (dueQ.size() != 0) @(negedge clk);
        @(posedge clk);  // Last returned slot reaches the DUT
        if (senderCredits() != QUEUE_DEPTH) begin
            reportError("sender credits were not all returned after the test");
        end
    endtask

    task automatic runArithTests();
        wordT a;
        wordT b;
        creditDelay <= 3;
        for (int f = 0; f < 4; f++) begin
            for (int k = 0; k < 6; k++) begin
                a = nextWord();
                b = nextWord();
                sendOp({3'b010, 2'(f)}, 2'b00, a, b);
                sendOp(opcRegAlu, 2'(f), a, b);
            end
        end
        sendOp(opcAddi, 2'b00, 16'h7FFF, 16'h0001);
        sendOp(opcRegAlu, 2'b00, 16'h8000, 16'h8000);
        sendOp(opcRegAlu, 2'b00, 16'h7FFF, 16'hFFFF);  // No overflow
        sendOp(opcSubi, 2'b00, 16'h0001, 16'h8000);
        sendOp(opcRegAlu, 2'b01, 16'hFFFF, 16'h7FFF);
        sendOp(opcRegAlu, 2'b01, 16'h0005, 16'h0003);
        finishTest();
    endtask

    task automatic runShiftTests();
        wordT a;
        wordT b;
        creditDelay <= 2;
        for (int kind = 0; kind < 4; kind++) begin
            for (int amt = 0; amt < 16; amt++) begin
                a = nextWord();
                b = nextWord();
                b[3:0] = 4'(amt);
                sendOp(opcRegShift, 2'(kind), a, b);
            end
        end
        for (int k = 0; k < 16; k++) begin
            a = nextWord();
            b = nextWord();
            sendOp({3'b101, 2'(k % 4)}, 2'b00, a, b);  // Immediate forms
        end
        finishTest();
    endtask

    task automatic runMiscTests();
        opcodeT cmp;
        creditDelay <= 1;
        for (int s = 0; s < 4; s++) begin
            cmp = {3'b111, 2'(s)};
            sendOp(cmp, 2'b00, 16'h1234, 16'h1234);
            sendOp(cmp, 2'b00, 16'hFFFF, 16'h0001);
            sendOp(cmp, 2'b00, 16'h0001, 16'hFFFF);
            sendOp(cmp, 2'b00, 16'h8000, 16'h7FFF);
            sendOp(cmp, 2'b00, nextWord(), nextWord());
        end
        for (int k = 0; k < 4; k++) begin
            sendOp(opcLbi, 2'b00, nextWord(), nextWord());
            sendOp(opcSlbi, 2'b00, nextWord(), nextWord());
            sendOp(opcBtr, 2'b00, nextWord(), nextWord());
        end
        for (int k = 0; k < 14; k++) begin
            sendOp(unsupportedOps[k], 2'(k % 4), nextWord(), nextWord());
        end
        finishTest();
    endtask

    task automatic runBackPressureTest();
        int seenBefore;
        seenBefore = resultsSeen;
        holdCredits <= 1'b1;
        creditDelay <= 0;
        for (int k = 0; k < QUEUE_DEPTH + RES_CREDITS; k++) begin
            sendOp(opcRegAlu, 2'(k % 4), nextWord(), nextWord());
        end
        opValid <= 1'b0;
        repeat (20) @(posedge clk);  // Stall window
        if (resultsSeen - seenBefore != RES_CREDITS) begin
            reportError("results kept flowing without downstream credits");
        end
        if (senderCredits() != 0) begin
            reportError("sender got credits back while the queue was stalled");
        end
        if (expRes.size() != QUEUE_DEPTH) begin
            reportError("queue did not hold the stalled ops");
        end
        holdCredits <= 1'b0;
        finishTest();
    endtask

    task automatic runStreamTest();
        creditDelay <= 0;
        timedOp = sentOps;
        for (int k = 0; k < 12; k++) begin
            if (k % 2 == 0) begin
                sendOp(opcRegAlu, 2'(k / 2 % 4), nextWord(), nextWord());
            end else begin
                sendOp(opcRegShift, 2'(k / 2 % 4), nextWord(), nextWord());
            end
        end
        finishTest();
    endtask

    // Downstream slot return
    always @(posedge clk) begin
        if (!rstN) begin
            resCredit <= 1'b0;
        end else if (!holdCredits && dueQ.size() != 0 && dueQ[0] <= cycleCount) begin
            resCredit <= 1'b1;
            void'(dueQ.pop_front());
        end else begin
            resCredit <= 1'b0;
        end
    end

    // Output monitor, samples between edges
    always @(negedge clk) begin
        cycleCount++;
        if (cycleCount > 40 * sentOps + 200) begin
            reportError("timeout, the run exceeded its cycle limit");
        end
        if (rstN) begin
            if (opCredit) begin
                returnedCredits++;
                if (senderCredits() > QUEUE_DEPTH) begin
                    reportError("sender credit count went above the queue depth");
                end
            end
            if (resValid) begin
                if (expRes.size() == 0) begin
                    reportError("result valid with no op outstanding");
                end else begin
                    checkWord($sformatf("result of op %0d", resultsSeen), expRes[0], result);
                    checkOvf($sformatf("ovf of op %0d", resultsSeen), expOvf[0], ovf);
                    if (resultsSeen == timedOp) begin
                        checkCycles("first stream latency", 2, cycleCount - expCycle[0]);
                    end
                    void'(expRes.pop_front());
                    void'(expOvf.pop_front());
                    void'(expCycle.pop_front());
                    resultsSeen++;
                    dueQ.push_back(cycleCount + creditDelay);
                    if (dueQ.size() > RES_CREDITS) begin
                        reportError("more results outstanding than downstream slots");
                    end
                end
            end
        end
    end

    initial begin
        rstN        <= 1'b0;
        opValid     <= 1'b0;
        opcode      <= '0;
        funct       <= '0;
        aIn         <= '0;
        bIn         <= '0;
        holdCredits <= 1'b0;
        creditDelay <= 0;
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        runArithTests();
        runShiftTests();
        runMiscTests();
        runBackPressureTest();
        runStreamTest();
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/execStage.sv
// Execute stage top level
`default_nettype none

module execStage #(
    parameter int QUEUE_DEPTH = 4,
    parameter int RES_CREDITS = 2
) (
    input  logic            clk,
    input  logic            rstN,
    input  logic            opValid,
    input  execPkg::opcodeT opcode,
    input  execPkg::functT  funct,
    input  execPkg::wordT   aIn,
    input  execPkg::wordT   bIn,
    input  logic            resCredit,
    output logic            opCredit,
    output logic            resValid,
    output execPkg::wordT   result,
    output logic            ovf
);
    import execPkg::*;

    logic      headValid;
    aluOpT     headOp;
    shiftKindT headKind;
    shamtT     headShamt;
    logic      headIsShift;
    wordT      headA;
    wordT      headB;
    logic      pop;
    wordT      aluResult;
    logic      aluOvf;
    wordT      shiftResult;

    opQueue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) queue (
        .clk        (clk),
        .rstN       (rstN),
        .opValid    (opValid),
        .opcode     (opcode),
        .funct      (funct),
        .aIn        (aIn),
        .bIn        (bIn),
        .pop        (pop),
        .headValid  (headValid),
        .headOp     (headOp),
        .headKind   (headKind),
        .headShamt  (headShamt),
        .headIsShift(headIsShift),
        .headA      (headA),
        .headB      (headB),
        .opCredit   (opCredit)
    );

    aluCore alu (
        .op    (headOp),
        .a     (headA),
        .b     (headB),
        .result(aluResult),
        .ovf   (aluOvf)
    );

    shiftCore shifter (
        .kind  (headKind),
        .shamt (headShamt),
        .a     (headA),
        .result(shiftResult)
    );

    resultMerge #(
        .RES_CREDITS(RES_CREDITS)
    ) merge (
        .clk        (clk),
        .rstN       (rstN),
        .headValid  (headValid),
        .headIsShift(headIsShift),
        .aluResult  (aluResult),
        .aluOvf     (aluOvf),
        .shiftResult(shiftResult),
        .resCredit  (resCredit),
        .pop        (pop),
        .resValid   (resValid),
        .result     (result),
        .ovf        (ovf)
    );

endmodule

`default_nettype wire

// File: verilog/resultMerge.sv
// Result select and output credit loop
`default_nettype none

module resultMerge #(
    parameter int RES_CREDITS = 2
) (
    input  logic          clk,
    input  logic          rstN,
    input  logic          headValid,
    input  logic          headIsShift,
    input  execPkg::wordT aluResult,
    input  logic          aluOvf,
    input  execPkg::wordT shiftResult,
    input  logic          resCredit,
    output logic          pop,
    output logic          resValid,
    output execPkg::wordT result,
    output logic          ovf
);
    import execPkg::*;

    localparam int creditWidth = $clog2(RES_CREDITS + 1);

    logic [creditWidth-1:0] creditCnt;
    wordT                   chosen;

    assign chosen = headIsShift ? shiftResult : aluResult;

    // Launch only with a free slot downstream
    assign pop = headValid && (creditCnt != '0);

    always_ff @(posedge clk) begin
        if (pop) begin
            result <= chosen;
            ovf    <= aluOvf;  // Zero for shifts
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            resValid  <= 1'b0;
            creditCnt <= creditWidth'(RES_CREDITS);
        end else begin
            resValid <= pop;
            // Credit is taken as the result is loaded
            case ({pop, resCredit})
                2'b10: creditCnt <= creditCnt - 1'b1;
                2'b01: creditCnt <= creditCnt + 1'b1;
                default: creditCnt <= creditCnt;
            endcase
        end
    end

    // Downstream never returns more than it was given
    assert property (@(posedge clk) disable iff (!rstN)
        creditCnt <= creditWidth'(RES_CREDITS))
        else $error("resultMerge: credit counter overflow");

endmodule

`default_nettype wire

// File: verilog/shiftCore.sv
// Logarithmic barrel shifter
`default_nettype none

module shiftCore (
    input  execPkg::shiftKindT kind,
    input  execPkg::shamtT     shamt,
    input  execPkg::wordT      a,
    output execPkg::wordT      result
);
    import execPkg::*;

    wordT stage1;
    wordT stage2;
    wordT stage4;

    // One stage, shift by n when enabled
    function automatic wordT shiftStage(wordT v, shiftKindT k, logic en, int unsigned n);
        wordT shifted;
        case (k)
            shSll:   shifted = v << n;  // Zero fill
            shSrl:   shifted = v >> n;
            shRol:   shifted = (v << n) | (v >> (dataWidth - n));
            default: shifted = (v >> n) | (v << (dataWidth - n));  // shRor
        endcase
        return en ? shifted : v;
    endfunction

    assign stage1 = shiftStage(a, kind, shamt[0], 1);
    assign stage2 = shiftStage(stage1, kind, shamt[1], 2);
    assign stage4 = shiftStage(stage2, kind, shamt[2], 4);
    assign result = shiftStage(stage4, kind, shamt[3], 8);

endmodule

`default_nettype wire

// File: verilog/aluCore.sv
// Integer logic and arithmetic core
`default_nettype none

module aluCore (
    input  execPkg::aluOpT op,
    input  execPkg::wordT  a,
    input  execPkg::wordT  b,
    output execPkg::wordT  result,
    output logic           ovf
);
    import execPkg::*;

    localparam int msb = dataWidth - 1;

    wordT sum;
    wordT diff;
    wordT revA;
    logic sumCarry;
    logic isEq;
    logic isLt;

    assign {sumCarry, sum} = {1'b0, a} + {1'b0, b};
    assign diff = b - a;  // B minus A
    assign isEq = (a == b);
    assign isLt = ($signed(a) < $signed(b));  // Signed compare

    // Bit reverse of A
    always_comb begin
        for (int i = 0; i < dataWidth; i++) begin
            revA[i] = a[msb - i];
        end
    end

    always_comb begin
        case (op)
            opAdd:   result = sum;
            opSub:   result = diff;
            opXor:   result = a ^ b;
            opAndn:  result = a & ~b;
            opSeq:   result = wordT'(isEq);
            opSlt:   result = wordT'(isLt);
            opSle:   result = wordT'(isLt | isEq);
            opSco:   result = wordT'(sumCarry);
            opLbi:   result = b;
            opSlbi:  result = (a << 8) | b;  // Byte load into low half
            opBtr:   result = revA;
            default: result = '0;  // NOP and shifts; shifter covers the latter
        endcase
    end

    // Signed overflow for add and subtract only
    always_comb begin
        case (op)
            opAdd:   ovf = (a[msb] == b[msb]) && (sum[msb] != a[msb]);
            opSub:   ovf = (b[msb] != a[msb]) && (diff[msb] != b[msb]);
            default: ovf = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/opQueue.sv
// Decoding input queue
`default_nettype none

module opQueue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic              opValid,
    input  execPkg::opcodeT   opcode,
    input  execPkg::functT    funct,
    input  execPkg::wordT     aIn,
    input  execPkg::wordT     bIn,
    input  logic              pop,
    output logic              headValid,
    output execPkg::aluOpT    headOp,
    output execPkg::shiftKindT headKind,
    output execPkg::shamtT    headShamt,
    output logic              headIsShift,
    output execPkg::wordT     headA,
    output execPkg::wordT     headB,
    output logic              opCredit
);
    import execPkg::*;

    localparam int ptrWidth = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int cntWidth = $clog2(QUEUE_DEPTH + 1);

    // Opcode groups, opcode[4:2]
    localparam logic [2:0] grpArithImm = 3'b010;
    localparam logic [2:0] grpMem      = 3'b100;
    localparam logic [2:0] grpShiftImm = 3'b101;
    localparam logic [2:0] grpReg      = 3'b110;
    localparam logic [2:0] grpCond     = 3'b111;

    aluOpT     opMem    [QUEUE_DEPTH];
    shiftKindT kindMem  [QUEUE_DEPTH];
    shamtT     shamtMem [QUEUE_DEPTH];
    logic      shiftMem [QUEUE_DEPTH];
    wordT      aMem     [QUEUE_DEPTH];
    wordT      bMem     [QUEUE_DEPTH];

    logic [ptrWidth-1:0] wrPtr;
    logic [ptrWidth-1:0] rdPtr;
    logic [cntWidth-1:0] count;
    logic                full;
    aluOpT               pushOp;

    function automatic aluOpT decodeOp(opcodeT opc, functT fn);
        aluOpT op;
        op = opNop;  // NOP, jump, branch, memory
        case (opc[4:2])
            grpArithImm: begin
                case (opc[1:0])
                    2'b00: op = opAdd;
                    2'b01: op = opSub;
                    2'b10: op = opXor;
                    default: op = opAndn;
                endcase
            end
            grpMem: begin
                if (opc[1:0] == 2'b10) begin
                    op = opSlbi;  // Only non-memory op in this group
                end
            end
            grpShiftImm: begin
                case (opc[1:0])
                    2'b00: op = opRol;
                    2'b01: op = opSll;
                    2'b10: op = opRor;
                    default: op = opSrl;
                endcase
            end
            grpReg: begin
                case (opc[1:0])
                    2'b11: begin
                        case (fn)
                            2'b00: op = opAdd;
                            2'b01: op = opSub;
                            2'b10: op = opXor;
                            default: op = opAndn;
                        endcase
                    end
                    2'b10: begin
                        case (fn)
                            2'b00: op = opSll;
                            2'b01: op = opSrl;
                            2'b10: op = opRol;
                            default: op = opRor;
                        endcase
                    end
                    2'b01: op = opBtr;
                    default: op = opLbi;
                endcase
            end
            grpCond: begin
                case (opc[1:0])
                    2'b00: op = opSeq;
                    2'b01: op = opSlt;
                    2'b10: op = opSle;
                    default: op = opSco;
                endcase
            end
            default: op = opNop;
        endcase
        return op;
    endfunction

    function automatic shiftKindT kindOf(aluOpT op);
        case (op)
            opSrl: return shSrl;
            opRol: return shRol;
            opRor: return shRor;
            default: return shSll;
        endcase
    endfunction

    function automatic logic [ptrWidth-1:0] nextPtr(logic [ptrWidth-1:0] ptr);
        if (ptr == ptrWidth'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign pushOp    = decodeOp(opcode, funct);
    assign full      = (count == cntWidth'(QUEUE_DEPTH));
    assign headValid = (count != '0);

    assign headOp      = opMem[rdPtr];
    assign headKind    = kindMem[rdPtr];
    assign headShamt   = shamtMem[rdPtr];
    assign headIsShift = shiftMem[rdPtr];
    assign headA       = aMem[rdPtr];
    assign headB       = bMem[rdPtr];

    always_ff @(posedge clk) begin
        if (opValid) begin
            opMem[wrPtr]    <= pushOp;
            kindMem[wrPtr]  <= kindOf(pushOp);
            shamtMem[wrPtr] <= bIn[3:0];  // Shift amount from B
            shiftMem[wrPtr] <= pushOp inside {opSll, opSrl, opRol, opRor};
            aMem[wrPtr]     <= aIn;
            bMem[wrPtr]     <= bIn;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            count    <= '0;
            opCredit <= 1'b0;
        end else begin
            if (opValid) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({opValid, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
            opCredit <= pop;  // One credit back per popped entry
        end
    end

    // Sender must hold a credit, so never pushes into a full queue
    assert property (@(posedge clk) disable iff (!rstN) opValid |-> !full)
        else $error("opQueue: push while full");

    // The merger only pops a valid head
    assert property (@(posedge clk) disable iff (!rstN) pop |-> headValid)
        else $error("opQueue: pop while empty");

endmodule

`default_nettype wire

// File: verilog/execPkg.sv
// Execute stage shared types
`default_nettype none

package execPkg;

    localparam int dataWidth = 16;  // Word width, fixed by the byte and shift ops

    typedef logic [dataWidth-1:0] wordT;  // Operand or result word
    typedef logic [4:0]           opcodeT;  // Instr[15:11]
    typedef logic [1:0]           functT;   // Instr[1:0]
    typedef logic [3:0]           shamtT;   // Low bits of B

    // Internal operation after decode
    typedef enum logic [3:0] {
        opNop,   // Also jumps, branches and memory ops
        opAdd,
        opSub,   // B minus A
        opXor,
        opAndn,  // A and not B
        opSeq,
        opSlt,
        opSle,
        opSco,   // Carry out of A plus B
        opLbi,
        opSlbi,
        opBtr,
        opSll,
        opSrl,
        opRol,
        opRor
    } aluOpT;

    typedef enum logic [1:0] {
        shSll,
        shSrl,
        shRol,
        shRor
    } shiftKindT;

endpackage

`default_nettype wire
